// File: cp0_pkg.sv
package cp0_pkg;

	// data word, used for register values and addresses
	typedef logic [31:0] word_t;

	// cp0 register number as found in the rd field of mtc0/mfc0
	typedef logic [4:0] reg_addr_t;

	// cause.exccode field
	typedef logic [4:0] exc_code_t;

	// one bit per hardware interrupt line
	typedef logic [5:0] irq_t;

	// register numbers
	localparam reg_addr_t REG_INDEX = 5'd0;

	// random is read-only, writes to it are dropped
	localparam reg_addr_t REG_RANDOM = 5'd1;

	localparam reg_addr_t REG_ENTRYLO0 = 5'd2;

	localparam reg_addr_t REG_ENTRYLO1 = 5'd3;

	localparam reg_addr_t REG_WIRED = 5'd6;

	localparam reg_addr_t REG_ENTRYHI = 5'd10;

	localparam reg_addr_t REG_STATUS = 5'd12;

	localparam reg_addr_t REG_CAUSE = 5'd13;

	localparam reg_addr_t REG_EPC = 5'd14;

	// exception codes
	localparam exc_code_t EXC_INT = 5'd0;

	// store to a page whose dirty bit is clear
	localparam exc_code_t EXC_MOD = 5'd1;

	localparam exc_code_t EXC_TLBL = 5'd2;

	localparam exc_code_t EXC_TLBS = 5'd3;

	localparam exc_code_t EXC_ADEL = 5'd4;

	localparam exc_code_t EXC_ADES = 5'd5;

	localparam exc_code_t EXC_SYS = 5'd8;

	// handler entry points in kseg0
	localparam word_t EXC_VECTOR = 32'h80000180;

	// tlb refill gets its own vector, only when exl was clear
	localparam word_t REFILL_VECTOR = 32'h80000000;

endpackage

// File: cp0_exc_prio.sv
`timescale 1ns/1ps

module cp0_exc_prio (
	input  logic              clk,
	input  logic              reset,
	input  logic              pause_i,
	input  logic              eret_i,
	input  logic              syscall_i,
	input  logic              addr_err_i,
	input  logic              tlb_refill_i,
	input  logic              tlb_invalid_i,
	input  logic              tlb_mod_i,
	input  logic              store_i,
	input  cp0_pkg::irq_t     irq_i,
	input  logic              status_ie_i,
	input  logic              status_exl_i,
	input  cp0_pkg::irq_t     status_im_i,
	input  cp0_pkg::word_t    epc_i,
	output logic              exc_taken_o,
	output logic              eret_taken_o,
	output logic              redirect_o,
	output cp0_pkg::exc_code_t exc_code_o,
	output cp0_pkg::irq_t     exc_ip_o,
	output cp0_pkg::word_t    redirect_pc_o
);

	logic int_req;
	logic any_exc;
	logic sel_refill;

	// only lines enabled in status.im can interrupt
	assign exc_ip_o = irq_i & status_im_i;

	assign int_req = (|exc_ip_o) && status_ie_i && !status_exl_i;

	assign any_exc = int_req || addr_err_i || tlb_mod_i || tlb_refill_i ||
		tlb_invalid_i || syscall_i;

	// nothing nests while exl is set, and a stall freezes everything
	assign exc_taken_o = any_exc && !status_exl_i && !pause_i;

	// eret loses to a simultaneous exception
	assign eret_taken_o = eret_i && !exc_taken_o && !pause_i;

	assign redirect_o = exc_taken_o || eret_taken_o;

	// fixed priority, interrupt first and syscall last
	always_comb
	begin
		if (int_req)
			exc_code_o = cp0_pkg::EXC_INT;
		else if (addr_err_i)
			exc_code_o = store_i ? cp0_pkg::EXC_ADES : cp0_pkg::EXC_ADEL;
		else if (tlb_mod_i)
			exc_code_o = cp0_pkg::EXC_MOD;
		else if (tlb_refill_i || tlb_invalid_i)
			exc_code_o = store_i ? cp0_pkg::EXC_TLBS : cp0_pkg::EXC_TLBL;
		else
			exc_code_o = cp0_pkg::EXC_SYS;
	end

	// refill wins the tlb slot only when nothing above it is pending
	assign sel_refill = !int_req && !addr_err_i && !tlb_mod_i && tlb_refill_i &&
		!status_exl_i;

	always_comb
	begin
		if (exc_taken_o)
			redirect_pc_o = sel_refill ? cp0_pkg::REFILL_VECTOR : cp0_pkg::EXC_VECTOR;
		else
			redirect_pc_o = epc_i;
	end

	a_exc_eret_excl: assert property (@(posedge clk) disable iff (reset)
		!(exc_taken_o && eret_taken_o));

	a_no_redirect_paused: assert property (@(posedge clk) disable iff (reset)
		pause_i |-> !redirect_o);

endmodule

// File: cp0_regs.sv
`timescale 1ns/1ps

module cp0_regs #(
	parameter int IDX_W = 4
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               pause_i,
	input  logic               mtc0_i,
	input  logic               mfc0_i,
	input  cp0_pkg::reg_addr_t addr_i,
	input  cp0_pkg::word_t     wdata_i,
	output cp0_pkg::word_t     rdata_o,
	input  logic               exc_taken_i,
	input  logic               eret_taken_i,
	input  cp0_pkg::exc_code_t exc_code_i,
	input  cp0_pkg::irq_t      exc_ip_i,
	input  cp0_pkg::word_t     pc_i,
	input  logic               probe_valid_i,
	input  logic               probe_miss_i,
	input  logic               tlbr_i,
	input  cp0_pkg::word_t     tlb_entryhi_i,
	input  cp0_pkg::word_t     tlb_entrylo0_i,
	input  cp0_pkg::word_t     tlb_entrylo1_i,
	output logic               status_ie_o,
	output logic               status_exl_o,
	output cp0_pkg::irq_t      status_im_o,
	output cp0_pkg::word_t     epc_o,
	output logic [IDX_W-1:0]   index_o,
	output logic [IDX_W-1:0]   random_o,
	output cp0_pkg::word_t     entryhi_o
);

	localparam logic [IDX_W-1:0] IDX_MAX = {IDX_W{1'b1}};

	logic             index_p;
	logic [IDX_W-1:0] index_idx;
	logic [IDX_W-1:0] random_q;
	logic [IDX_W-1:0] wired_q;
	logic [25:0]      entrylo0_q;
	logic [25:0]      entrylo1_q;
	logic [18:0]      entryhi_vpn2;
	logic [7:0]       entryhi_asid;
	logic             status_um;
	logic [5:0]       cause_ip;
	cp0_pkg::exc_code_t cause_code;
	cp0_pkg::word_t   epc_q;
	cp0_pkg::word_t   rd_val;
	logic             wr_en;

	assign wr_en = mtc0_i && !pause_i;

	// control state: status, cause, index.p, random, wired
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			index_p <= 1'b0;
			random_q <= IDX_MAX;
			wired_q <= '0;
			status_im_o <= '0;
			status_um <= 1'b0;
			status_exl_o <= 1'b0;
			status_ie_o <= 1'b0;
			cause_ip <= '0;
			cause_code <= '0;
		end
		else if (!pause_i)
		begin
			if (probe_valid_i)
				index_p <= probe_miss_i;

			// wired write restarts random from the top
			if (wr_en && addr_i == cp0_pkg::REG_WIRED)
			begin
				wired_q <= wdata_i[IDX_W-1:0];
				random_q <= IDX_MAX;
			end
			else if (random_q == IDX_MAX)
				random_q <= wired_q;
			else
				random_q <= random_q + 1'b1;

			if (wr_en && addr_i == cp0_pkg::REG_STATUS)
			begin
				status_im_o <= wdata_i[15:10];
				status_um <= wdata_i[4];
				status_exl_o <= wdata_i[1];
				status_ie_o <= wdata_i[0];
			end
			else if (eret_taken_i)
				status_exl_o <= 1'b0;

			if (exc_taken_i && exc_code_i == cp0_pkg::EXC_INT)
				cause_ip <= exc_ip_i;
			if (wr_en && addr_i == cp0_pkg::REG_CAUSE)
			begin
				cause_ip <= wdata_i[15:10];
				cause_code <= wdata_i[6:2];
			end

			// exception commit overrides a software write
			if (exc_taken_i)
			begin
				status_exl_o <= 1'b1;
				cause_code <= exc_code_i;
			end
		end
	end

	// payload registers
	always_ff @(posedge clk)
	begin
		if (!pause_i)
		begin
			if (wr_en && addr_i == cp0_pkg::REG_INDEX)
				index_idx <= wdata_i[IDX_W-1:0];

			if (wr_en && addr_i == cp0_pkg::REG_ENTRYLO0)
				entrylo0_q <= wdata_i[25:0];
			else if (tlbr_i)
				entrylo0_q <= tlb_entrylo0_i[25:0];

			if (wr_en && addr_i == cp0_pkg::REG_ENTRYLO1)
				entrylo1_q <= wdata_i[25:0];
			else if (tlbr_i)
				entrylo1_q <= tlb_entrylo1_i[25:0];

			if (wr_en && addr_i == cp0_pkg::REG_ENTRYHI)
			begin
				entryhi_vpn2 <= wdata_i[31:13];
				entryhi_asid <= wdata_i[7:0];
			end
			else if (tlbr_i)
			begin
				entryhi_vpn2 <= tlb_entryhi_i[31:13];
				entryhi_asid <= tlb_entryhi_i[7:0];
			end

			if (wr_en && addr_i == cp0_pkg::REG_EPC)
				epc_q <= wdata_i;
			if (exc_taken_i)
				epc_q <= pc_i;
		end
	end

	// read mux, unimplemented numbers give 0
	always_comb
	begin
		rd_val = '0;
		case (addr_i)
			cp0_pkg::REG_INDEX:
			begin
				rd_val[31] = index_p;
				rd_val[IDX_W-1:0] = index_idx;
			end
			cp0_pkg::REG_RANDOM: rd_val[IDX_W-1:0] = random_q;
			cp0_pkg::REG_ENTRYLO0: rd_val = {6'b0, entrylo0_q};
			cp0_pkg::REG_ENTRYLO1: rd_val = {6'b0, entrylo1_q};
			cp0_pkg::REG_WIRED: rd_val[IDX_W-1:0] = wired_q;
			cp0_pkg::REG_ENTRYHI: rd_val = entryhi_o;
			cp0_pkg::REG_STATUS:
				rd_val = {16'b0, status_im_o, 5'b0, status_um, 2'b0, status_exl_o, status_ie_o};
			cp0_pkg::REG_CAUSE: rd_val = {16'b0, cause_ip, 3'b0, cause_code, 2'b0};
			cp0_pkg::REG_EPC: rd_val = epc_q;
			default: rd_val = '0;
		endcase
	end

	assign rdata_o = mfc0_i ? rd_val : '0;

	assign epc_o = epc_q;
	assign index_o = index_idx;
	assign random_o = random_q;
	assign entryhi_o = {entryhi_vpn2, 5'b0, entryhi_asid};

	// random stays inside the unwired part of the tlb
	a_random_above_wired: assert property (@(posedge clk) disable iff (reset)
		random_q >= wired_q);

endmodule

// File: cp0_top.sv
`timescale 1ns/1ps

module cp0_top #(
	parameter int IDX_W = 4
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               mtc0_i,
	input  logic               mfc0_i,
	input  logic               eret_i,
	input  logic               syscall_i,
	input  cp0_pkg::reg_addr_t addr_i,
	input  cp0_pkg::word_t     wdata_i,
	input  logic               addr_err_i,
	input  logic               tlb_refill_i,
	input  logic               tlb_invalid_i,
	input  logic               tlb_mod_i,
	input  logic               store_i,
	input  cp0_pkg::irq_t      irq_i,
	input  cp0_pkg::word_t     pc_i,
	input  logic               probe_valid_i,
	input  logic               probe_miss_i,
	input  logic               tlbr_i,
	input  cp0_pkg::word_t     tlb_entryhi_i,
	input  cp0_pkg::word_t     tlb_entrylo0_i,
	input  cp0_pkg::word_t     tlb_entrylo1_i,
	input  logic               pause_i,
	output cp0_pkg::word_t     rdata_o,
	output logic               redirect_o,
	output cp0_pkg::word_t     redirect_pc_o,
	output logic [IDX_W-1:0]   index_o,
	output logic [IDX_W-1:0]   random_o,
	output cp0_pkg::word_t     entryhi_o
);

	logic               exc_taken;
	logic               eret_taken;
	cp0_pkg::exc_code_t exc_code;
	cp0_pkg::irq_t      exc_ip;
	logic               status_ie;
	logic               status_exl;
	cp0_pkg::irq_t      status_im;
	cp0_pkg::word_t     epc;

	// picks one cause per cycle and the redirect target
	cp0_exc_prio u_prio (
		.clk           (clk),
		.reset         (reset),
		.pause_i       (pause_i),
		.eret_i        (eret_i),
		.syscall_i     (syscall_i),
		.addr_err_i    (addr_err_i),
		.tlb_refill_i  (tlb_refill_i),
		.tlb_invalid_i (tlb_invalid_i),
		.tlb_mod_i     (tlb_mod_i),
		.store_i       (store_i),
		.irq_i         (irq_i),
		.status_ie_i   (status_ie),
		.status_exl_i  (status_exl),
		.status_im_i   (status_im),
		.epc_i         (epc),
		.exc_taken_o   (exc_taken),
		.eret_taken_o  (eret_taken),
		.redirect_o    (redirect_o),
		.exc_code_o    (exc_code),
		.exc_ip_o      (exc_ip),
		.redirect_pc_o (redirect_pc_o)
	);

	cp0_regs #(
		.IDX_W (IDX_W)
	) u_regs (
		.clk            (clk),
		.reset          (reset),
		.pause_i        (pause_i),
		.mtc0_i         (mtc0_i),
		.mfc0_i         (mfc0_i),
		.addr_i         (addr_i),
		.wdata_i        (wdata_i),
		.rdata_o        (rdata_o),
		.exc_taken_i    (exc_taken),
		.eret_taken_i   (eret_taken),
		.exc_code_i     (exc_code),
		.exc_ip_i       (exc_ip),
		.pc_i           (pc_i),
		.probe_valid_i  (probe_valid_i),
		.probe_miss_i   (probe_miss_i),
		.tlbr_i         (tlbr_i),
		.tlb_entryhi_i  (tlb_entryhi_i),
		.tlb_entrylo0_i (tlb_entrylo0_i),
		.tlb_entrylo1_i (tlb_entrylo1_i),
		.status_ie_o    (status_ie),
		.status_exl_o   (status_exl),
		.status_im_o    (status_im),
		.epc_o          (epc),
		.index_o        (index_o),
		.random_o       (random_o),
		.entryhi_o      (entryhi_o)
	);

endmodule

// File: tb_cp0.sv
`timescale 1ns/1ps

module tb_cp0;

	localparam int IDX_W = 4;
	localparam int SEED = 38591;
	localparam string STIM_FILE = "cp0_stimulus.txt";
	localparam logic [31:0] RANDOM_TOP = (1 << IDX_W) - 1;

	logic clk;
	logic reset;
	logic mtc0, mfc0, eret, syscall;
	logic [4:0] addr;
	logic [31:0] wdata;
	logic addr_err, tlb_refill, tlb_invalid, tlb_mod, store;
	logic [5:0] irq;
	logic [31:0] pc;
	logic probe_valid, probe_miss, tlbr;
	logic [31:0] tlb_entryhi, tlb_entrylo0, tlb_entrylo1;
	logic pause;
	logic [31:0] rdata;
	logic redirect;
	logic [31:0] redirect_pc;
	logic [IDX_W-1:0] index_out;
	logic [IDX_W-1:0] random_out;
	logic [31:0] entryhi_out;

	// expected random and wired from the counter rules
	logic [IDX_W-1:0] ref_random;
	logic [IDX_W-1:0] ref_wired;

	// one entry per stimulus line
	string step_name[$];
	logic [15:0] step_flags[$];
	logic [4:0] step_addr[$];
	logic [31:0] step_wdata[$];
	logic [5:0] step_irq[$];
	logic [31:0] step_pc[$];
	string exp_rdata[$];
	string exp_redirect[$];
	string exp_pc[$];

	int errors = 0;
	int cycles = 0;
	int limit = 0;

	cp0_top #(
		.IDX_W (IDX_W)
	) u_dut (
		.clk            (clk),
		.reset          (reset),
		.mtc0_i         (mtc0),
		.mfc0_i         (mfc0),
		.eret_i         (eret),
		.syscall_i      (syscall),
		.addr_i         (addr),
		.wdata_i        (wdata),
		.addr_err_i     (addr_err),
		.tlb_refill_i   (tlb_refill),
		.tlb_invalid_i  (tlb_invalid),
		.tlb_mod_i      (tlb_mod),
		.store_i        (store),
		.irq_i          (irq),
		.pc_i           (pc),
		.probe_valid_i  (probe_valid),
		.probe_miss_i   (probe_miss),
		.tlbr_i         (tlbr),
		.tlb_entryhi_i  (tlb_entryhi),
		.tlb_entrylo0_i (tlb_entrylo0),
		.tlb_entrylo1_i (tlb_entrylo1),
		.pause_i        (pause),
		.rdata_o        (rdata),
		.redirect_o     (redirect),
		.redirect_pc_o  (redirect_pc),
		.index_o        (index_out),
		.random_o       (random_out),
		.entryhi_o      (entryhi_out)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// random counts up when unpaused and wraps to wired
	always @(posedge clk)
	begin
		if (reset)
		begin
			ref_random <= RANDOM_TOP[IDX_W-1:0];
			ref_wired <= '0;
		end
		else if (!pause)
		begin
			if (mtc0 && addr == cp0_pkg::REG_WIRED)
			begin
				ref_wired <= wdata[IDX_W-1:0];
				ref_random <= RANDOM_TOP[IDX_W-1:0];
			end
			else if (ref_random == RANDOM_TOP[IDX_W-1:0])
				ref_random <= ref_wired;
			else
				ref_random <= ref_random + 1'b1;
		end
	end

	task automatic load_steps();
		int fd;
		int n;
		string line;
		string name;
		string e_rd;
		string e_rdr;
		string e_pc;
		logic [15:0] fl;
		logic [4:0] ad;
		logic [31:0] wd;
		logic [5:0] iq;
		logic [31:0] pcv;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
		begin
			$display("could not open the stimulus file %s", STIM_FILE);
			errors++;
			return;
		end
		while (!$feof(fd))
		begin
			line = "";
			void'($fgets(line, fd));
			// skip blank lines and comments
			if (line.len() < 2 || line.getc(0) == 8'h23)
				continue;
			n = $sscanf(line, "%s %h %h %h %h %h %s %s %s",
				name, fl, ad, wd, iq, pcv, e_rd, e_rdr, e_pc);
			if (n != 9)
			begin
				$display("stimulus line could not be parsed: %s", line);
				errors++;
			end
			else
			begin
				step_name.push_back(name);
				step_flags.push_back(fl);
				step_addr.push_back(ad);
				step_wdata.push_back(wd);
				step_irq.push_back(iq);
				step_pc.push_back(pcv);
				exp_rdata.push_back(e_rd);
				exp_redirect.push_back(e_rdr);
				exp_pc.push_back(e_pc);
			end
		end
		$fclose(fd);
	endtask

	// flag bits follow the column notes in the stimulus file
	task automatic drive_step(input int i);
		logic [15:0] fl;
		fl = step_flags[i];
		mtc0 = fl[0];
		mfc0 = fl[1];
		eret = fl[2];
		syscall = fl[3];
		addr_err = fl[4];
		tlb_refill = fl[5];
		tlb_invalid = fl[6];
		tlb_mod = fl[7];
		store = fl[8];
		probe_valid = fl[9];
		probe_miss = fl[10];
		tlbr = fl[11];
		pause = fl[12];
		addr = step_addr[i];
		wdata = step_wdata[i];
		irq = step_irq[i];
		pc = step_pc[i];
		// a tlb read returns wdata for entryhi and entrylo0, its inverse for entrylo1
		tlb_entryhi = step_wdata[i];
		tlb_entrylo0 = step_wdata[i];
		tlb_entrylo1 = ~step_wdata[i];
	endtask

	task automatic drive_idle(input logic p);
		{mtc0, mfc0, eret, syscall} = '0;
		{addr_err, tlb_refill, tlb_invalid, tlb_mod, store} = '0;
		{probe_valid, probe_miss, tlbr} = '0;
		addr = '0;
		wdata = '0;
		irq = '0;
		pc = '0;
		tlb_entryhi = '0;
		tlb_entrylo0 = '0;
		tlb_entrylo1 = '0;
		pause = p;
	endtask

	// tok is a hex value, a dash to skip, or wN for a random read in N..top
	task automatic check_value(input string test, input string what, input string tok,
		input logic [31:0] actual);
		logic [31:0] expected;
		logic [31:0] lo;
		if (tok == "-")
			return;
		if (tok.getc(0) == 8'h77)
		begin
			void'($sscanf(tok.substr(1, tok.len() - 1), "%h", lo));
			if ($isunknown(actual) || actual < lo || actual > RANDOM_TOP)
			begin
				$display("Error: %0s %0s expected %0h..%0h actual %h",
					test, what, lo, RANDOM_TOP, actual);
				errors++;
			end
		end
		else
		begin
			void'($sscanf(tok, "%h", expected));
			if (actual !== expected)
			begin
				$display("Error: %0s %0s expected %h actual %h", test, what, expected, actual);
				errors++;
			end
		end
	endtask

	// index_o and entryhi_o follow the value read from their register
	task automatic compare_tlb_outputs(input int i);
		logic [31:0] expected;
		if (!step_flags[i][1] || exp_rdata[i] == "-" || exp_rdata[i].getc(0) == 8'h77)
			return;
		void'($sscanf(exp_rdata[i], "%h", expected));
		if (step_addr[i] == cp0_pkg::REG_INDEX && index_out !== expected[IDX_W-1:0])
		begin
			$display("Error: %0s index_o expected %h actual %h",
				step_name[i], expected[IDX_W-1:0], index_out);
			errors++;
		end
		if (step_addr[i] == cp0_pkg::REG_ENTRYHI && entryhi_out !== expected)
		begin
			$display("Error: %0s entryhi_o expected %h actual %h",
				step_name[i], expected, entryhi_out);
			errors++;
		end
	endtask

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit)
		begin
			$display("the run timed out after %0d cycles", cycles);
			$display("errors: %0d", errors);
			$display("Test FAILED");
			$finish;
		end
	end

	initial
	begin
		logic p;
		reset = 1'b1;
		drive_idle(1'b0);
		void'($urandom(SEED));
		load_steps();
		if (step_name.size() == 0)
		begin
			$display("the stimulus file holds no test steps");
			errors++;
		end
		limit = 4 * step_name.size() + 200;
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		for (int i = 0; i < step_name.size(); i++)
		begin
			drive_step(i);
			// sample just before the next edge
			#8;
			check_value(step_name[i], "rdata", exp_rdata[i], rdata);
			check_value(step_name[i], "redirect", exp_redirect[i], {31'b0, redirect});
			check_value(step_name[i], "redirect_pc", exp_pc[i], redirect_pc);
			compare_tlb_outputs(i);
			if (random_out !== ref_random)
			begin
				$display("Error: %0s random_o expected %h actual %h",
					step_name[i], ref_random, random_out);
				errors++;
			end
			@(posedge clk);
			#1;
			// flag bit 13 keeps the next step in the very next cycle
			if (!step_flags[i][13])
			begin
				do
				begin
					p = $urandom % 2;
					drive_idle(p);
					@(posedge clk);
					#1;
				end
				while (p);
			end
		end
		$display("errors: %0d", errors);
		if (errors == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

// File: cp0_stimulus.txt
# name flags addr wdata irq pc exp_rdata exp_redirect exp_redirect_pc (hex, - = don't care)
# flags 1 mtc0 2 mfc0 4 eret 8 syscall 10 addr_err 20 refill 40 invalid 80 mod 100 store
# 200 probe 400 miss 800 tlbr 1000 pause 2000 no idle after; wN = random read within N..f
rst_random      0002 01 00000000 00 00000000 0000000f 0 -
rst_status      0002 0c 00000000 00 00000000 00000000 0 -
rst_wired       0002 06 00000000 00 00000000 00000000 0 -
wr_index        0001 00 8000fff5 00 00000000 - 0 -
rd_index        0002 00 00000000 00 00000000 00000005 0 -
wr_entrylo0     0001 02 ffffffff 00 00000000 - 0 -
rd_entrylo0     0002 02 00000000 00 00000000 03ffffff 0 -
wr_entryhi      0001 0a ffffffff 00 00000000 - 0 -
rd_entryhi      0002 0a 00000000 00 00000000 ffffe0ff 0 -
wr_epc          0001 0e 12345678 00 00000000 - 0 -
rd_epc          0002 0e 00000000 00 00000000 12345678 0 -
wr_status       0001 0c fffffffe 00 00000000 - 0 -
rd_status       0002 0c 00000000 00 00000000 0000fc12 0 -
eret_wr         0004 00 00000000 00 00000000 - 1 12345678
wr_cause        0001 0d ffffffff 00 00000000 - 0 -
rd_cause        0002 0d 00000000 00 00000000 0000fc7c 0 -
wr_random       0001 01 00000003 00 00000000 - 0 -
rd_random       0002 01 00000000 00 00000000 w0 0 -
rd_unimpl       0002 09 00000000 00 00000000 00000000 0 -
syscall         0008 00 00000000 00 00400100 - 1 80000180
rd_cause_sys    0002 0d 00000000 00 00000000 0000fc20 0 -
rd_epc_sys      0002 0e 00000000 00 00000000 00400100 0 -
rd_status_exl   0002 0c 00000000 00 00000000 0000fc12 0 -
nested_sys      0008 00 00000000 00 00400200 - 0 -
eret_sys        0004 00 00000000 00 00000000 - 1 00400100
adel            0010 00 00000000 00 00400300 - 1 80000180
eret_adel       0006 0d 00000000 00 00000000 0000fc10 1 00400300
ades            0110 00 00000000 00 00400400 - 1 80000180
eret_ades       0006 0d 00000000 00 00000000 0000fc14 1 00400400
refill          0020 00 00000000 00 00400500 - 1 80000000
eret_refill     0006 0d 00000000 00 00000000 0000fc08 1 00400500
prio_ades       01b8 00 00000000 00 00400600 - 1 80000180
eret_prio_ades  0006 0d 00000000 00 00000000 0000fc14 1 00400600
prio_mod        01a0 00 00000000 00 00400680 - 1 80000180
eret_prio_mod   0006 0d 00000000 00 00000000 0000fc04 1 00400680
irq_no_ie       0000 00 00000000 3f 00400700 - 0 -
wr_status_ie    0001 0c 00001401 00 00000000 - 0 -
irq_masked      0000 00 00000000 0a 00400700 - 0 -
irq_sys         0008 00 00000000 0f 00400700 - 1 80000180
eret_irq        0006 0d 00000000 00 00000000 00001400 1 00400700
wr_status_exl   0001 0c 00001403 00 00000000 - 0 -
irq_exl         0000 00 00000000 05 00400780 - 0 -
clr_status      0001 0c 00000000 00 00000000 - 0 -
pause_all       100b 0e deadbeef 00 00400800 00400700 0 -
rd_epc_pause    0002 0e 00000000 00 00000000 00400700 0 -
rd_status_pause 0002 0c 00000000 00 00000000 00000000 0 -
probe_miss      0602 00 00000000 00 00000000 00000005 0 -
probe_hit       0202 00 00000000 00 00000000 80000005 0 -
rd_index_hit    0002 00 00000000 00 00000000 00000005 0 -
tlbr            0800 00 12345678 00 00000000 - 0 -
rd_tlb_entryhi  0002 0a 00000000 00 00000000 12344078 0 -
rd_tlb_entrylo0 0002 02 00000000 00 00000000 02345678 0 -
rd_tlb_entrylo1 0002 03 00000000 00 00000000 01cba987 0 -
wr_wired        2001 06 00000003 00 00000000 - 0 -
rd_random_top   0002 01 00000000 00 00000000 0000000f 0 -
rd_wired        0002 06 00000000 00 00000000 00000003 0 -
rd_random_a     0002 01 00000000 00 00000000 w3 0 -
rd_random_b     0002 01 00000000 00 00000000 w3 0 -

// File: files.f
cp0_pkg.sv
cp0_exc_prio.sv
cp0_regs.sv
cp0_top.sv
tb_cp0.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = tb_cp0
FILELIST  = files.f
BUILD_DIR = obj_dir
PASS_MSG  = Test OK

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
